// ==== fpu_unit.f ====
rtl/fpu_pkg.sv
rtl/fp_round.sv
rtl/int_to_float.sv
rtl/float_to_int.sv
rtl/fp_sign_cmp.sv
rtl/fpu_ctrl.sv
rtl/fpu_unit.sv
tests/fpu_unit_chk.sv
tests/tb_fpu_unit.sv

// ==== rtl/float_to_int.sv ====
`timescale 1ns/1ps

module float_to_int (
	input  logic [31:0]          f,
	input  logic                 is_signed,
	input  fpu_pkg::round_mode_e rm,
	output logic [31:0]          res,
	output logic                 nv,
	output logic                 nx
);
	import fpu_pkg::*;

	// Binary point sits at bit POINT of the wide shifter.
	localparam int WIDE_W    = 96;
	localparam int POINT     = 64;
	localparam int SHIFT_OFS = EXP_BIAS + FRAC_W - POINT;

	logic              sign;
	logic [EXP_W-1:0]  exp;
	logic [FRAC_W:0]   sig;
	logic              is_nan;
	logic              too_big;
	logic              too_small;
	logic [6:0]        shamt;
	logic [WIDE_W-1:0] wide;
	logic [31:0]       int_part;
	logic              guard;
	logic              round_bit;
	logic              sticky;
	logic [31:0]       mag;
	logic              carry;
	logic              inexact;
	logic              invalid;

	assign sign   = f[31];
	assign exp    = f[FRAC_W +: EXP_W];
	// Subnormals flush to zero.
	assign sig    = {(exp != '0), f[FRAC_W-1:0]} & {(FRAC_W + 1){exp != '0}};
	assign is_nan = (&exp) & (|f[FRAC_W-1:0]);

	// Magnitude of 2^32 or more, also inf and NaN.
	assign too_big   = int'(exp) > EXP_BIAS + 31;
	// Below 0.25 only sticky survives.
	assign too_small = int'(exp) < EXP_BIAS - 2;

	assign shamt = 7'(exp - EXP_W'(SHIFT_OFS));
	assign wide  = {{(WIDE_W - FRAC_W - 1){1'b0}}, sig} << shamt;

	always_comb begin
		if (too_small) begin
			int_part  = '0;
			guard     = 1'b0;
			round_bit = 1'b0;
			sticky    = |sig;
		end else begin
			int_part  = wide[POINT +: 32];
			guard     = wide[POINT-1];
			round_bit = wide[POINT-2];
			sticky    = |wide[POINT-3:0];
		end
	end

	fp_round #(
		.MANT_W(32)
	) i_round (
		.sign     (sign),
		.mant     (int_part),
		.guard    (guard),
		.round_bit(round_bit),
		.sticky   (sticky),
		.rm       (rm),
		.rounded  (mag),
		.carry    (carry),
		.inexact  (inexact)
	);

	always_comb begin
		if (is_signed) begin
			invalid = too_big | carry | (sign ? (mag > 32'h8000_0000) : mag[31]);
		end else begin
			invalid = too_big | carry | (sign & (mag != '0));
		end

		if (is_nan) begin
			res = is_signed ? 32'h7fff_ffff : 32'hffff_ffff;
		end else if (invalid) begin
			if (is_signed) begin
				res = sign ? 32'h8000_0000 : 32'h7fff_ffff;
			end else begin
				res = sign ? 32'h0000_0000 : 32'hffff_ffff;
			end
		end else begin
			res = sign ? -mag : mag;
		end

		nv = invalid;
		// Invalid conversions raise NV only.
		nx = inexact & ~invalid;
	end

endmodule

// ==== rtl/fp_round.sv ====
`timescale 1ns/1ps

module fp_round #(
	parameter int MANT_W = 24
) (
	input  logic                 sign,
	input  logic [MANT_W-1:0]    mant,
	input  logic                 guard,
	input  logic                 round_bit,
	input  logic                 sticky,
	input  fpu_pkg::round_mode_e rm,
	output logic [MANT_W-1:0]    rounded,
	output logic                 carry,
	output logic                 inexact
);
	import fpu_pkg::*;

	logic inc;

	assign inexact = guard | round_bit | sticky;

	// Increment decision per mode.
	always_comb begin
		case (rm)
			RM_RTZ: begin
				inc = 1'b0;
			end
			RM_RDN: begin
				inc = sign & inexact;
			end
			RM_RUP: begin
				inc = ~sign & inexact;
			end
			RM_RMM: begin
				inc = guard;
			end
			default: begin
				// Ties go to the even mantissa.
				inc = guard & (round_bit | sticky | mant[0]);
			end
		endcase
	end

	assign {carry, rounded} = {1'b0, mant} + {{MANT_W{1'b0}}, inc};

endmodule

// ==== rtl/fp_sign_cmp.sv ====
`timescale 1ns/1ps

module fp_sign_cmp (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [1:0]  sgn_mode,
	input  logic [1:0]  cmp_mode,
	output logic [31:0] res,
	output logic        nv
);
	import fpu_pkg::*;

	localparam int MAG_W = EXP_W + FRAC_W;

	logic             a_nan;
	logic             b_nan;
	logic             a_snan;
	logic             b_snan;
	logic [MAG_W-1:0] a_mag;
	logic [MAG_W-1:0] b_mag;
	logic             eq;
	logic             lt;
	logic             hit;
	logic             sgn;

	assign a_nan  = (&a[FRAC_W +: EXP_W]) & (|a[FRAC_W-1:0]);
	assign b_nan  = (&b[FRAC_W +: EXP_W]) & (|b[FRAC_W-1:0]);
	// Quiet NaNs share the top bits of the canonical NaN.
	assign a_snan = a_nan & (a[MAG_W-1:FRAC_W-1] != CANON_NAN[MAG_W-1:FRAC_W-1]);
	assign b_snan = b_nan & (b[MAG_W-1:FRAC_W-1] != CANON_NAN[MAG_W-1:FRAC_W-1]);

	// Subnormals compare as zero.
	assign a_mag = (a[FRAC_W +: EXP_W] == '0) ? '0 : a[MAG_W-1:0];
	assign b_mag = (b[FRAC_W +: EXP_W] == '0) ? '0 : b[MAG_W-1:0];

	always_comb begin
		if (a_mag == '0 && b_mag == '0) begin
			eq = 1'b1;
			lt = 1'b0;
		end else if (a[31] != b[31]) begin
			eq = 1'b0;
			lt = a[31];
		end else begin
			eq = (a_mag == b_mag);
			lt = a[31] ? (a_mag > b_mag) : (a_mag < b_mag);
		end
	end

	always_comb begin
		case (sgn_mode)
			SGN_J:   sgn = b[31];
			SGN_JN:  sgn = ~b[31];
			SGN_JX:  sgn = a[31] ^ b[31];
			default: sgn = a[31];
		endcase

		hit = 1'b0;
		nv  = 1'b0;
		case (cmp_mode)
			CMP_EQ: begin
				hit = eq;
				nv  = a_snan | b_snan;
			end
			CMP_LT: begin
				hit = lt;
				nv  = a_nan | b_nan;
			end
			CMP_LE: begin
				hit = lt | eq;
				nv  = a_nan | b_nan;
			end
			default: ;
		endcase

		if (cmp_mode == CMP_NONE) begin
			res = {sgn, a[MAG_W-1:0]};
		end else begin
			res = {31'b0, hit & ~(a_nan | b_nan)};
		end
	end

endmodule

// ==== rtl/fpu_ctrl.sv ====
`timescale 1ns/1ps

module fpu_ctrl (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  fpu_pkg::fpu_op_e     op,
	input  fpu_pkg::round_mode_e rm,
	input  logic [31:0]          opa,
	input  logic [31:0]          opb,
	output logic [31:0]          s1_a,
	output logic [31:0]          s1_b,
	output fpu_pkg::round_mode_e s1_rm,
	output logic                 cvt_signed,
	output logic [1:0]           sgn_mode,
	output logic [1:0]           cmp_mode,
	input  logic [31:0]          i2f_res,
	input  logic                 i2f_nx,
	input  logic [31:0]          f2i_res,
	input  logic                 f2i_nv,
	input  logic                 f2i_nx,
	input  logic [31:0]          sc_res,
	input  logic                 sc_nv,
	output logic                 res_valid,
	output logic [31:0]          res,
	output fpu_pkg::fflags_t     flags
);
	import fpu_pkg::*;

	fpu_op_e     s1_op;
	logic        s1_valid;
	logic [31:0] sel_res;
	logic        sel_nv;
	logic        sel_nx;
	fflags_t     sel_flags;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= start;
		end
	end

	// Stage 1 operands.
	always_ff @(posedge clk) begin
		if (start) begin
			s1_op <= op;
			s1_a  <= opa;
			s1_b  <= opb;
			case (rm)
				RM_RTZ, RM_RDN, RM_RUP, RM_RMM: s1_rm <= rm;
				// Reserved codes round to nearest even.
				default: s1_rm <= RM_RNE;
			endcase
		end
	end

	always_comb begin
		cvt_signed = (s1_op == OP_CVT_S_W) || (s1_op == OP_CVT_W_S);
		sgn_mode   = SGN_KEEP;
		cmp_mode   = CMP_NONE;
		case (s1_op)
			OP_SGNJ:  sgn_mode = SGN_J;
			OP_SGNJN: sgn_mode = SGN_JN;
			OP_SGNJX: sgn_mode = SGN_JX;
			OP_FEQ:   cmp_mode = CMP_EQ;
			OP_FLT:   cmp_mode = CMP_LT;
			OP_FLE:   cmp_mode = CMP_LE;
			default: ;
		endcase
	end

	// Result and flag select.
	always_comb begin
		sel_res = sc_res;
		sel_nv  = sc_nv;
		sel_nx  = 1'b0;
		case (s1_op)
			OP_CVT_S_W, OP_CVT_S_WU: begin
				sel_res = i2f_res;
				sel_nv  = 1'b0;
				sel_nx  = i2f_nx;
			end
			OP_CVT_W_S, OP_CVT_WU_S: begin
				sel_res = f2i_res;
				sel_nv  = f2i_nv;
				sel_nx  = f2i_nx;
			end
			OP_SGNJ, OP_SGNJN, OP_SGNJX: begin
				sel_nv = 1'b0;
			end
			default: ;
		endcase
		sel_flags          = '0;
		sel_flags[FLAG_NV] = sel_nv;
		sel_flags[FLAG_NX] = sel_nx;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
			res       <= '0;
			flags     <= '0;
		end else begin
			res_valid <= s1_valid;
			// Idle cycles show zero.
			if (s1_valid) begin
				res   <= sel_res;
				flags <= sel_flags;
			end else begin
				res   <= '0;
				flags <= '0;
			end
		end
	end

endmodule

// ==== rtl/fpu_pkg.sv ====
package fpu_pkg;

	// Single-precision field widths.
	localparam int EXP_W    = 8;
	localparam int FRAC_W   = 23;
	localparam int EXP_BIAS = 127;

	localparam logic [31:0] CANON_NAN = 32'h7fc0_0000;

	typedef enum logic [3:0] {
		OP_CVT_S_W,
		OP_CVT_S_WU,
		OP_CVT_W_S,
		OP_CVT_WU_S,
		OP_SGNJ,
		OP_SGNJN,
		OP_SGNJX,
		OP_FEQ,
		OP_FLT,
		OP_FLE
	} fpu_op_e;

	// RISC-V frm encodings.
	typedef enum logic [2:0] {
		RM_RNE = 3'd0,
		RM_RTZ = 3'd1,
		RM_RDN = 3'd2,
		RM_RUP = 3'd3,
		RM_RMM = 3'd4
	} round_mode_e;

	// Order is NV, DZ, OF, UF, NX.
	typedef logic [4:0] fflags_t;

	localparam int FLAG_NV = 4;
	localparam int FLAG_NX = 0;

	// Sign injection selects.
	localparam logic [1:0] SGN_J    = 2'd0;
	localparam logic [1:0] SGN_JN   = 2'd1;
	localparam logic [1:0] SGN_JX   = 2'd2;
	localparam logic [1:0] SGN_KEEP = 2'd3;

	// Compare selects. CMP_NONE passes the sign injection result.
	localparam logic [1:0] CMP_EQ   = 2'd0;
	localparam logic [1:0] CMP_LT   = 2'd1;
	localparam logic [1:0] CMP_LE   = 2'd2;
	localparam logic [1:0] CMP_NONE = 2'd3;

endpackage

// ==== rtl/fpu_unit.sv ====
`timescale 1ns/1ps

module fpu_unit (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  fpu_pkg::fpu_op_e     op,
	input  fpu_pkg::round_mode_e rm,
	input  logic [31:0]          opa,
	input  logic [31:0]          opb,
	output logic                 res_valid,
	output logic [31:0]          res,
	output fpu_pkg::fflags_t     flags
);
	import fpu_pkg::*;

	logic [31:0] s1_a;
	logic [31:0] s1_b;
	round_mode_e s1_rm;
	logic        cvt_signed;
	logic [1:0]  sgn_mode;
	logic [1:0]  cmp_mode;
	logic [31:0] i2f_res;
	logic        i2f_nx;
	logic [31:0] f2i_res;
	logic        f2i_nv;
	logic        f2i_nx;
	logic [31:0] sc_res;
	logic        sc_nv;

	fpu_ctrl i_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.op        (op),
		.rm        (rm),
		.opa       (opa),
		.opb       (opb),
		.s1_a      (s1_a),
		.s1_b      (s1_b),
		.s1_rm     (s1_rm),
		.cvt_signed(cvt_signed),
		.sgn_mode  (sgn_mode),
		.cmp_mode  (cmp_mode),
		.i2f_res   (i2f_res),
		.i2f_nx    (i2f_nx),
		.f2i_res   (f2i_res),
		.f2i_nv    (f2i_nv),
		.f2i_nx    (f2i_nx),
		.sc_res    (sc_res),
		.sc_nv     (sc_nv),
		.res_valid (res_valid),
		.res       (res),
		.flags     (flags)
	);

	int_to_float i_i2f (
		.a        (s1_a),
		.is_signed(cvt_signed),
		.rm       (s1_rm),
		.res      (i2f_res),
		.nx       (i2f_nx)
	);

	float_to_int i_f2i (
		.f        (s1_a),
		.is_signed(cvt_signed),
		.rm       (s1_rm),
		.res      (f2i_res),
		.nv       (f2i_nv),
		.nx       (f2i_nx)
	);

	fp_sign_cmp i_sc (
		.a       (s1_a),
		.b       (s1_b),
		.sgn_mode(sgn_mode),
		.cmp_mode(cmp_mode),
		.res     (sc_res),
		.nv      (sc_nv)
	);

endmodule

// ==== rtl/int_to_float.sv ====
`timescale 1ns/1ps

module int_to_float (
	input  logic [31:0]          a,
	input  logic                 is_signed,
	input  fpu_pkg::round_mode_e rm,
	output logic [31:0]          res,
	output logic                 nx
);
	import fpu_pkg::*;

	logic              neg;
	logic [31:0]       mag;
	logic [4:0]        msb;
	logic [31:0]       norm;
	logic [FRAC_W:0]   rounded;
	logic              carry;
	logic [EXP_W-1:0]  exp;

	assign neg = is_signed & a[31];
	assign mag = neg ? -a : a;

	// Leading one position.
	always_comb begin
		msb = '0;
		for (int i = 0; i < 32; i++) begin
			if (mag[i]) begin
				msb = 5'(i);
			end
		end
	end

	assign norm = mag << (5'd31 - msb);

	fp_round #(
		.MANT_W(24)
	) i_round (
		.sign     (neg),
		.mant     (norm[31:8]),
		.guard    (norm[7]),
		.round_bit(norm[6]),
		.sticky   (|norm[5:0]),
		.rm       (rm),
		.rounded  (rounded),
		.carry    (carry),
		.inexact  (nx)
	);

	// Carry out means the mantissa wrapped to 1.0.
	assign exp = EXP_W'(msb) + EXP_W'(EXP_BIAS) + EXP_W'(carry);

	assign res = (a == '0) ? '0 : {neg, exp, rounded[FRAC_W-1:0]};

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the FPU testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f fpu_unit.f \
	--top-module tb_fpu_unit -o sim_fpu_unit > sim.log 2>&1 \
	&& ./obj_dir/sim_fpu_unit >> sim.log 2>&1 \
	|| echo "TESTBENCH FAILED" >> sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }

// ==== tests/fpu_testdata.txt ====
# columns: op rm opa opb expected_res expected_flags, all hex
# op 0 cvt.s.w 1 cvt.s.wu 2 cvt.w.s 3 cvt.wu.s 4 sgnj 5 sgnjn 6 sgnjx 7 feq 8 flt 9 fle
# integer to float
0 0 00000000 00000000 00000000 00
0 1 00000000 00000000 00000000 00
0 2 00000000 00000000 00000000 00
0 3 00000000 00000000 00000000 00
0 4 00000000 00000000 00000000 00
0 0 00000001 00000000 3F800000 00
0 1 00000001 00000000 3F800000 00
0 2 00000001 00000000 3F800000 00
0 3 00000001 00000000 3F800000 00
0 4 00000001 00000000 3F800000 00
0 0 80000000 00000000 CF000000 00
0 1 80000000 00000000 CF000000 00
0 2 80000000 00000000 CF000000 00
0 3 80000000 00000000 CF000000 00
0 4 80000000 00000000 CF000000 00
0 0 7FFFFFFF 00000000 4F000000 01
0 1 7FFFFFFF 00000000 4EFFFFFF 01
0 2 7FFFFFFF 00000000 4EFFFFFF 01
0 3 7FFFFFFF 00000000 4F000000 01
0 4 7FFFFFFF 00000000 4F000000 01
1 0 FFFFFFFF 00000000 4F800000 01
1 1 FFFFFFFF 00000000 4F7FFFFF 01
1 2 FFFFFFFF 00000000 4F7FFFFF 01
1 3 FFFFFFFF 00000000 4F800000 01
1 4 FFFFFFFF 00000000 4F800000 01
0 2 80000001 00000000 CF000000 01
0 3 80000001 00000000 CEFFFFFF 01
0 0 01000001 00000000 4B800000 01
0 4 01000001 00000000 4B800001 01
# float to integer
2 0 40200000 00000000 00000002 01
2 1 40200000 00000000 00000002 01
2 2 40200000 00000000 00000002 01
2 3 40200000 00000000 00000003 01
2 4 40200000 00000000 00000003 01
2 0 C0200000 00000000 FFFFFFFE 01
2 1 C0200000 00000000 FFFFFFFE 01
2 2 C0200000 00000000 FFFFFFFD 01
2 3 C0200000 00000000 FFFFFFFE 01
2 4 C0200000 00000000 FFFFFFFD 01
2 0 40600000 00000000 00000004 01
2 0 3F800000 00000000 00000001 00
2 0 7FC00000 00000000 7FFFFFFF 10
2 0 7F800000 00000000 7FFFFFFF 10
2 0 FF800000 00000000 80000000 10
2 0 4F000000 00000000 7FFFFFFF 10
2 0 CF000000 00000000 80000000 00
3 0 C0200000 00000000 00000000 10
3 0 BE800000 00000000 00000000 01
3 2 BE800000 00000000 00000000 10
3 0 4F7FFFFF 00000000 FFFFFF00 00
3 0 7FC00000 00000000 FFFFFFFF 10
# sign injection
4 0 3F800000 C0000000 BF800000 00
5 0 3F800000 C0000000 3F800000 00
6 0 BF800000 C0000000 3F800000 00
4 0 00000000 80000000 80000000 00
5 0 7FC00000 7F800001 FFC00000 00
6 0 FF800001 00000000 FF800001 00
# compares
7 0 3F800000 3F800000 00000001 00
8 0 3F800000 40000000 00000001 00
8 0 40000000 3F800000 00000000 00
9 0 BF800000 BF800000 00000001 00
8 0 C0000000 BF800000 00000001 00
7 0 00000000 80000000 00000001 00
8 0 80000000 00000000 00000000 00
9 0 80000000 00000000 00000001 00
7 0 7FC00000 3F800000 00000000 00
7 0 7F800001 3F800000 00000000 10
8 0 7FC00000 3F800000 00000000 10
9 0 3F800000 7F800001 00000000 10
# mixed operations back to back
4 0 3F800000 80000000 BF800000 00
0 0 00000001 00000000 3F800000 00
7 0 3F800000 3F800000 00000001 00
2 3 40200000 00000000 00000003 01
1 0 FFFFFFFF 00000000 4F800000 01
# reserved rounding modes act as RNE
0 5 7FFFFFFF 00000000 4F000000 01
2 6 40200000 00000000 00000002 01
0 7 01000001 00000000 4B800000 01

// ==== tests/fpu_unit_chk.sv ====
`timescale 1ns/1ps

module fpu_unit_chk (
	input logic             clk,
	input logic             rst_n,
	input logic             start,
	input logic             res_valid,
	input fpu_pkg::fflags_t flags
);

	// Result two edges after the start.
	valid_follows_start: assert property (
		@(posedge clk) disable iff (!rst_n) res_valid == $past(start, 2)
	) else $error("res_valid does not follow start by two cycles");

	// Only NV and NX are ever raised.
	unused_flags_zero: assert property (
		@(posedge clk) disable iff (!rst_n) flags[3:1] == 3'b000
	) else $error("DZ, OF or UF flag is set");

	idle_flags_zero: assert property (
		@(posedge clk) disable iff (!rst_n) !res_valid |-> flags == '0
	) else $error("flags are nonzero while res_valid is low");

endmodule

bind fpu_unit fpu_unit_chk i_chk (
	.clk      (clk),
	.rst_n    (rst_n),
	.start    (start),
	.res_valid(res_valid),
	.flags    (flags)
);

// ==== tests/tb_fpu_unit.sv ====
`timescale 1ns/1ps

module tb_fpu_unit;
	import fpu_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_CYCLES = 8;

	logic        clk;
	logic        rst_n;
	logic        start;
	fpu_op_e     op;
	round_mode_e rm;
	logic [31:0] opa;
	logic [31:0] opb;
	logic        res_valid;
	logic [31:0] res;
	fflags_t     flags;

	// Vectors as read from the data file.
	logic [3:0]  vec_op[$];
	logic [2:0]  vec_rm[$];
	logic [31:0] vec_a[$];
	logic [31:0] vec_b[$];
	logic [31:0] vec_res[$];
	fflags_t     vec_flags[$];
	int          vec_idle[$];

	// Expected results of the operations in flight, oldest first.
	logic [31:0] exp_res_q[$];
	fflags_t     exp_flags_q[$];
	int          exp_idx_q[$];

	int seed = 73;
	int total_idle = 0;
	int watchdog_cycles = 0;
	bit vectors_loaded = 1'b0;
	int res_errors = 0;
	int flag_errors = 0;
	int protocol_errors = 0;

	fpu_unit i_fpu_unit (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.op       (op),
		.rm       (rm),
		.opa      (opa),
		.opb      (opb),
		.res_valid(res_valid),
		.res      (res),
		.flags    (flags)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic load_vectors();
		int          fd;
		int          n;
		string       tok;
		string       rest;
		logic [3:0]  v_op;
		logic [2:0]  v_rm;
		logic [31:0] v_a;
		logic [31:0] v_b;
		logic [31:0] v_res;
		fflags_t     v_flags;
		bit          gap;
		int          idle;
		fd = $fopen("tests/fpu_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/fpu_testdata.txt");
			protocol_errors++;
			return;
		end
		gap = 1'b0;
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok.substr(0, 0) == "#") begin
				// A comment line opens a new group.
				n = $fgets(rest, fd);
				gap = (vec_op.size() != 0);
			end else begin
				n = $sscanf(tok, "%h", v_op);
				n += $fscanf(fd, "%h %h %h %h %h", v_rm, v_a, v_b, v_res, v_flags);
				if (n != 6) begin
					$display("malformed vector line after vector %0d", vec_op.size());
					protocol_errors++;
				end else begin
					idle = gap ? (int'($random(seed) & 7) + 2) : 0;
					total_idle += idle;
					vec_op.push_back(v_op);
					vec_rm.push_back(v_rm);
					vec_a.push_back(v_a);
					vec_b.push_back(v_b);
					vec_res.push_back(v_res);
					vec_flags.push_back(v_flags);
					vec_idle.push_back(idle);
				end
				gap = 1'b0;
			end
		end
		$fclose(fd);
	endtask

	task automatic apply_vector(input int k);
		start = 1'b1;
		op    = fpu_op_e'(vec_op[k]);
		rm    = round_mode_e'(vec_rm[k]);
		opa   = vec_a[k];
		opb   = vec_b[k];
		exp_res_q.push_back(vec_res[k]);
		exp_flags_q.push_back(vec_flags[k]);
		exp_idx_q.push_back(k);
	endtask

	task automatic check_res(input string what, input logic [31:0] want,
		input logic [31:0] got);
		if (got !== want) begin
			$display("FAILED res: expected %h, got %h (%s)", want, got, what);
			res_errors++;
		end
	endtask

	task automatic check_flags(input string what, input fflags_t want, input fflags_t got);
		if (got !== want) begin
			$display("FAILED flags: expected %h, got %h (%s)", want, got, what);
			flag_errors++;
		end
	endtask

	// Outputs change on the rising edge and are sampled on the falling one.
	always @(negedge clk) begin
		logic [31:0] want_res;
		fflags_t     want_flags;
		int          idx;
		if (rst_n && res_valid) begin
			if (exp_res_q.size() == 0) begin
				$display("result valid at %0t ns with no operation outstanding", $time);
				protocol_errors++;
			end else begin
				want_res   = exp_res_q.pop_front();
				want_flags = exp_flags_q.pop_front();
				idx        = exp_idx_q.pop_front();
				check_res($sformatf("vector %0d", idx), want_res, res);
				check_flags($sformatf("vector %0d", idx), want_flags, flags);
			end
		end
	end

	initial begin
		int drain;
		rst_n = 1'b0;
		start = 1'b0;
		op    = OP_CVT_S_W;
		rm    = RM_RNE;
		opa   = '0;
		opb   = '0;
		load_vectors();
		watchdog_cycles = RESET_CYCLES + vec_op.size() + total_idle + 20;
		vectors_loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_res("after reset", '0, res);
		check_flags("after reset", '0, flags);

		for (int k = 0; k < vec_op.size(); k++) begin
			repeat (vec_idle[k]) begin
				@(negedge clk);
				start = 1'b0;
			end
			@(negedge clk);
			apply_vector(k);
		end
		@(negedge clk);
		start = 1'b0;

		drain = 0;
		while (exp_res_q.size() != 0 && drain < DRAIN_CYCLES) begin
			@(negedge clk);
			drain++;
		end
		if (exp_res_q.size() != 0) begin
			$display("%0d expected results never arrived", exp_res_q.size());
			protocol_errors += exp_res_q.size();
		end

		$display("errors: res %0d, flags %0d, protocol %0d",
			res_errors, flag_errors, protocol_errors);
		if (res_errors + flag_errors + protocol_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// Limit follows from reset, vector count and idle gaps.
	initial begin
		wait (vectors_loaded);
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout after %0d cycles with %0d results outstanding",
			watchdog_cycles, exp_res_q.size());
		$display("errors: res %0d, flags %0d, protocol %0d",
			res_errors, flag_errors, protocol_errors);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
